// File: design/hwpe_beat_collect.sv
// HWPE write beat collector
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_beat_collect (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  hwpe_pkg::lane_item_t [`HWPE_N_LANES-1:0] items_i,
  input  logic [`HWPE_LEN_W-1:0]                   off_i,
  input  logic [`HWPE_ADDR_W-1:0]                  dst_i,
  output logic                                     wr_o,
  output logic [`HWPE_ADDR_W-1:0]                  wr_addr_o,
  output logic [`HWPE_BEAT_W-1:0]                  wr_data_o
);

  logic [`HWPE_LEN_W-1:0]   off_q;
  logic                     wr_q;
  logic [`HWPE_ADDR_W-1:0]  wr_addr_q;
  logic [`HWPE_BEAT_W-1:0]  wr_data_q;
  logic [`HWPE_N_LANES-1:0] lane_valid;
  logic [`HWPE_BEAT_W-1:0]  beat;

  // lanes run in lockstep, a beat is complete once every lane holds a word
  always_comb begin
    for (int i = 0; i < `HWPE_N_LANES; i++) begin
      lane_valid[i] = items_i[i].valid;
      beat[i*`HWPE_WORD_W +: `HWPE_WORD_W] = items_i[i].word;
    end
  end

  // the lane stage adds one cycle, so the offset is held once more
  always_ff @(posedge clk_i) begin
    off_q <= off_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= &lane_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (&lane_valid) begin
      wr_addr_q <= dst_i + `HWPE_ADDR_W'(off_q);
      wr_data_q <= beat;
    end
  end

  // this strobe doubles as the write-done count for the controller
  assign wr_o      = wr_q;
  assign wr_addr_o = wr_addr_q;
  assign wr_data_o = wr_data_q;

endmodule

// File: design/hwpe_beat_dispatch.sv
// HWPE read beat dispatcher
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_beat_dispatch (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  hwpe_pkg::mem_rsp_t                         rsp_i,
  input  logic [`HWPE_LEN_W-1:0]                     off_i,
  output hwpe_pkg::lane_item_t [`HWPE_N_LANES-1:0]   items_o,
  output logic [`HWPE_LEN_W-1:0]                     off_o
);

  logic [`HWPE_LEN_W-1:0]                     off_d_q;
  logic [`HWPE_LEN_W-1:0]                     off_q;
  logic [`HWPE_N_LANES-1:0]                   valid_q;
  logic [`HWPE_N_LANES-1:0][`HWPE_WORD_W-1:0] word_q;

  // memory answers one cycle after the strobe, the offset waits with it
  always_ff @(posedge clk_i) begin
    off_d_q <= off_i;
    off_q   <= off_d_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {`HWPE_N_LANES{rsp_i.rvalid}};
    end
  end

  // lane 0 takes the lowest word of the beat
  always_ff @(posedge clk_i) begin
    if (rsp_i.rvalid) begin
      word_q <= rsp_i.rdata;
    end
  end

  always_comb begin
    for (int i = 0; i < `HWPE_N_LANES; i++) begin
      items_o[i] = '{valid: valid_q[i], word: word_q[i]};
    end
  end

  assign off_o = off_q;

endmodule

// File: design/hwpe_cfg_regs.sv
// HWPE configuration register file
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_cfg_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  hwpe_pkg::cfg_req_t  cfg_i,
  output hwpe_pkg::cfg_rsp_t  cfg_o,
  input  logic                busy_i,
  output hwpe_pkg::job_cfg_t  job_o,
  output logic                start_o
);

  logic [`HWPE_ADDR_W-1:0] src_q;
  logic [`HWPE_ADDR_W-1:0] dst_q;
  logic [`HWPE_LEN_W-1:0]  len_q;
  hwpe_pkg::hwpe_op_e      op_q;
  logic [`HWPE_WORD_W-1:0] konst_q;
  hwpe_pkg::job_cfg_t      job_q;
  logic                    rvalid_q;
  logic [`HWPE_WORD_W-1:0] rdata_q;
  logic                    wr_en;
  logic                    rd_en;

  // the register file is locked while a job runs, reads stay open
  assign wr_en = cfg_i.valid & cfg_i.we & ~busy_i;
  assign rd_en = cfg_i.valid & ~cfg_i.we;

  // an empty job never starts, so a zero length trigger is dropped
  assign start_o = wr_en && (cfg_i.addr == hwpe_pkg::REG_TRIGGER) && (len_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      op_q    <= hwpe_pkg::OP_COPY;
      konst_q <= '0;
    end else if (wr_en) begin
      case (cfg_i.addr)
        hwpe_pkg::REG_SRC:   src_q   <= cfg_i.wdata[`HWPE_ADDR_W-1:0];
        hwpe_pkg::REG_DST:   dst_q   <= cfg_i.wdata[`HWPE_ADDR_W-1:0];
        hwpe_pkg::REG_LEN:   len_q   <= cfg_i.wdata[`HWPE_LEN_W-1:0];
        hwpe_pkg::REG_OP:    op_q    <= hwpe_pkg::hwpe_op_e'(cfg_i.wdata[1:0]);
        hwpe_pkg::REG_CONST: konst_q <= cfg_i.wdata;
        // trigger and status hold no state here
        default: ;
      endcase
    end
  end

  // snapshot of the job so later register writes cannot disturb it
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      job_q <= '{src: src_q, dst: dst_q, len: len_q, op: op_q, konst: konst_q};
    end
  end

  // read answers come back exactly one cycle after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (cfg_i.addr)
        hwpe_pkg::REG_SRC:    rdata_q <= `HWPE_WORD_W'(src_q);
        hwpe_pkg::REG_DST:    rdata_q <= `HWPE_WORD_W'(dst_q);
        hwpe_pkg::REG_LEN:    rdata_q <= `HWPE_WORD_W'(len_q);
        hwpe_pkg::REG_OP:     rdata_q <= `HWPE_WORD_W'(op_q);
        hwpe_pkg::REG_CONST:  rdata_q <= konst_q;
        // status carries busy in bit 0
        hwpe_pkg::REG_STATUS: rdata_q <= `HWPE_WORD_W'(busy_i);
        default:              rdata_q <= '0;
      endcase
    end
  end

  assign cfg_o = '{rvalid: rvalid_q, rdata: rdata_q};
  assign job_o = job_q;

endmodule

// File: design/hwpe_config.svh
// HWPE subsystem build constants
`ifndef HWPE_CONFIG_SVH
`define HWPE_CONFIG_SVH

// number of 32-bit lanes in one memory beat
`define HWPE_N_LANES 4

// width of a single lane word
`define HWPE_WORD_W 32

// beat address width, the memory holds 4096 beats
`define HWPE_ADDR_W 12

// job length in beats, also used for the in-flight beat offset
`define HWPE_LEN_W 8

// a full beat as seen on the memory port
`define HWPE_BEAT_W (`HWPE_N_LANES * `HWPE_WORD_W)

`endif

// File: design/hwpe_ctrl.sv
// HWPE job controller
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  hwpe_pkg::job_cfg_t      job_i,
  input  logic                    wr_done_i,
  output logic                    rd_o,
  output logic [`HWPE_ADDR_W-1:0] rd_addr_o,
  output logic [`HWPE_LEN_W-1:0]  rd_off_o,
  output logic                    busy_o,
  output logic                    evt_o
);

  hwpe_pkg::ctrl_state_e  state_q;
  logic [`HWPE_LEN_W-1:0] rd_cnt_q;
  logic [`HWPE_LEN_W-1:0] wr_cnt_q;
  logic                   evt_q;
  logic [`HWPE_LEN_W-1:0] len_m1;
  logic                   last_rd;
  logic                   last_wr;

  // both counters run from zero up to len-1
  assign len_m1  = job_i.len - `HWPE_LEN_W'(1);
  assign last_rd = (rd_cnt_q == len_m1);
  assign last_wr = wr_done_i && (wr_cnt_q == len_m1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= hwpe_pkg::ST_IDLE;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
      evt_q    <= 1'b0;
    end else begin
      evt_q <= 1'b0;
      case (state_q)
        hwpe_pkg::ST_IDLE: begin
          if (start_i) begin
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
            state_q  <= hwpe_pkg::ST_READ;
          end
        end
        hwpe_pkg::ST_READ: begin
          // one read strobe per cycle, writes may already come back here
          rd_cnt_q <= rd_cnt_q + `HWPE_LEN_W'(1);
          if (wr_done_i) begin
            wr_cnt_q <= wr_cnt_q + `HWPE_LEN_W'(1);
          end
          if (last_rd) begin
            state_q <= hwpe_pkg::ST_DRAIN;
          end
        end
        hwpe_pkg::ST_DRAIN: begin
          if (wr_done_i) begin
            wr_cnt_q <= wr_cnt_q + `HWPE_LEN_W'(1);
          end
          // the event lands in the same cycle that busy drops
          if (last_wr) begin
            evt_q   <= 1'b1;
            state_q <= hwpe_pkg::ST_IDLE;
          end
        end
        default: state_q <= hwpe_pkg::ST_IDLE;
      endcase
    end
  end

  assign rd_o      = (state_q == hwpe_pkg::ST_READ);
  assign rd_off_o  = rd_cnt_q;
  assign rd_addr_o = job_i.src + `HWPE_ADDR_W'(rd_cnt_q);
  assign busy_o    = (state_q != hwpe_pkg::ST_IDLE);
  assign evt_o     = evt_q;

endmodule

// File: design/hwpe_lane.sv
// HWPE single lane stage
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_lane (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  hwpe_pkg::lane_item_t    item_i,
  input  hwpe_pkg::hwpe_op_e      op_i,
  input  logic [`HWPE_WORD_W-1:0] konst_i,
  output hwpe_pkg::lane_item_t    item_o
);

  logic                    valid_q;
  logic [`HWPE_WORD_W-1:0] word_q;
  logic [`HWPE_WORD_W-1:0] result;

  // add wraps modulo 2^32 since the carry is simply dropped
  always_comb begin
    case (op_i)
      hwpe_pkg::OP_COPY: result = item_i.word;
      hwpe_pkg::OP_ADD:  result = item_i.word + konst_i;
      hwpe_pkg::OP_XOR:  result = item_i.word ^ konst_i;
      hwpe_pkg::OP_FILL: result = konst_i;
      default:           result = item_i.word;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= item_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (item_i.valid) begin
      word_q <= result;
    end
  end

  assign item_o = '{valid: valid_q, word: word_q};

endmodule

// File: design/hwpe_pkg.sv
// HWPE shared types and register map
`include "hwpe_config.svh"

package hwpe_pkg;

  // per-word transform applied by every lane
  typedef enum logic [1:0] {
    OP_COPY,
    OP_ADD,
    OP_XOR,
    OP_FILL
  } hwpe_op_e;

  // job controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_DRAIN
  } ctrl_state_e;

  // register offsets on the configuration port
  localparam logic [2:0] REG_SRC     = 3'd0;
  localparam logic [2:0] REG_DST     = 3'd1;
  localparam logic [2:0] REG_LEN     = 3'd2;
  localparam logic [2:0] REG_OP      = 3'd3;
  localparam logic [2:0] REG_CONST   = 3'd4;
  localparam logic [2:0] REG_TRIGGER = 3'd5;
  localparam logic [2:0] REG_STATUS  = 3'd6;

  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [2:0]              addr;
    logic [`HWPE_WORD_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                    rvalid;
    logic [`HWPE_WORD_W-1:0] rdata;
  } cfg_rsp_t;

  // read and write carry their own address so both can go out in one cycle
  typedef struct packed {
    logic                    rd;
    logic [`HWPE_ADDR_W-1:0] rd_addr;
    logic                    wr;
    logic [`HWPE_ADDR_W-1:0] wr_addr;
    logic [`HWPE_BEAT_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                    rvalid;
    logic [`HWPE_BEAT_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                    valid;
    logic [`HWPE_WORD_W-1:0] word;
  } lane_item_t;

  // job snapshot taken when the trigger is accepted
  typedef struct packed {
    logic [`HWPE_ADDR_W-1:0] src;
    logic [`HWPE_ADDR_W-1:0] dst;
    logic [`HWPE_LEN_W-1:0]  len;
    hwpe_op_e                op;
    logic [`HWPE_WORD_W-1:0] konst;
  } job_cfg_t;

endpackage

// File: design/hwpe_subsystem.sv
// HWPE subsystem top level
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_subsystem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hwpe_pkg::cfg_req_t cfg_i,
  output hwpe_pkg::cfg_rsp_t cfg_o,
  output hwpe_pkg::mem_req_t mem_o,
  input  hwpe_pkg::mem_rsp_t mem_i,
  output logic               evt_o,
  output logic               busy_o
);

  hwpe_pkg::job_cfg_t                     job;
  logic                                   start;
  logic                                   busy;
  logic                                   rd;
  logic [`HWPE_ADDR_W-1:0]                rd_addr;
  logic [`HWPE_LEN_W-1:0]                 rd_off;
  hwpe_pkg::lane_item_t [`HWPE_N_LANES-1:0] disp_items;
  logic [`HWPE_LEN_W-1:0]                 disp_off;
  hwpe_pkg::lane_item_t [`HWPE_N_LANES-1:0] lane_items;
  logic                                   wr;
  logic [`HWPE_ADDR_W-1:0]                wr_addr;
  logic [`HWPE_BEAT_W-1:0]                wr_data;

  hwpe_cfg_regs cfg_regs_inst (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .cfg_i   ( cfg_i   ),
    .cfg_o   ( cfg_o   ),
    .busy_i  ( busy    ),
    .job_o   ( job     ),
    .start_o ( start   )
  );

  // the collector's write strobe closes the loop on the job count
  hwpe_ctrl ctrl_inst (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .start_i   ( start   ),
    .job_i     ( job     ),
    .wr_done_i ( wr      ),
    .rd_o      ( rd      ),
    .rd_addr_o ( rd_addr ),
    .rd_off_o  ( rd_off  ),
    .busy_o    ( busy    ),
    .evt_o     ( evt_o   )
  );

  hwpe_beat_dispatch dispatch_inst (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .rsp_i   ( mem_i      ),
    .off_i   ( rd_off     ),
    .items_o ( disp_items ),
    .off_o   ( disp_off   )
  );

  // one identical stage per 32-bit word of the beat
  for (genvar i = 0; i < `HWPE_N_LANES; i++) begin : gen_lane
    hwpe_lane lane_inst (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .item_i  ( disp_items[i] ),
      .op_i    ( job.op        ),
      .konst_i ( job.konst     ),
      .item_o  ( lane_items[i] )
    );
  end

  hwpe_beat_collect collect_inst (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .items_i   ( lane_items ),
    .off_i     ( disp_off   ),
    .dst_i     ( job.dst    ),
    .wr_o      ( wr         ),
    .wr_addr_o ( wr_addr    ),
    .wr_data_o ( wr_data    )
  );

  // read side comes from the controller, write side from the collector
  assign mem_o.rd      = rd;
  assign mem_o.rd_addr = rd_addr;
  assign mem_o.wr      = wr;
  assign mem_o.wr_addr = wr_addr;
  assign mem_o.wdata   = wr_data;
  assign busy_o        = busy;

endmodule

// File: flist.f
+incdir+design
design/hwpe_pkg.sv
design/hwpe_cfg_regs.sv
design/hwpe_ctrl.sv
design/hwpe_beat_dispatch.sv
design/hwpe_lane.sv
design/hwpe_beat_collect.sv
design/hwpe_subsystem.sv
tests/hwpe_subsystem_chk.sv
tests/hwpe_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the HWPE subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
  --top-module hwpe_subsystem_tb --Mdir obj_dir -o hwpe_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/hwpe_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

// File: tests/hwpe_subsystem_chk.sv
// HWPE top-level protocol checks
`timescale 1ns/1ps

module hwpe_subsystem_chk (
  input logic               clk_i,
  input logic               rst_n_i,
  input hwpe_pkg::mem_req_t mem_req_i,
  input hwpe_pkg::mem_rsp_t mem_rsp_i,
  input logic               evt_i,
  input logic               busy_i
);

  // memory traffic belongs to a running job, the last write still sees busy
  mem_in_job: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_i.rd || mem_req_i.wr) |-> busy_i)
    else $error("memory strobe while the engine is idle");

  evt_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_i |=> !evt_i)
    else $error("completion event held for more than one cycle");

  // the event marks exactly the cycle in which busy drops
  evt_on_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_i == $fell(busy_i))
    else $error("completion event and falling busy are not aligned");

  rsp_after_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> $past(mem_req_i.rd))
    else $error("read data returned without a read strobe");

endmodule

bind hwpe_subsystem hwpe_subsystem_chk chk_inst (
  .clk_i     ( clk_i   ),
  .rst_n_i   ( rst_n_i ),
  .mem_req_i ( mem_o   ),
  .mem_rsp_i ( mem_i   ),
  .evt_i     ( evt_o   ),
  .busy_i    ( busy_o  )
);

// File: tests/hwpe_subsystem_tb.sv
// HWPE subsystem testbench
`timescale 1ns/1ps
`include "hwpe_config.svh"

module hwpe_subsystem_tb;

  localparam int N_JOBS    = 6;
  localparam int MEM_BEATS = 1 << `HWPE_ADDR_W;

  // poke asks for register writes while the job is still running
  typedef struct packed {
    logic [`HWPE_ADDR_W-1:0] src;
    logic [`HWPE_ADDR_W-1:0] dst;
    logic [`HWPE_LEN_W-1:0]  len;
    hwpe_pkg::hwpe_op_e      op;
    logic [`HWPE_WORD_W-1:0] konst;
    logic                    poke;
  } job_row_t;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  hwpe_pkg::cfg_req_t      cfg_i;
  hwpe_pkg::cfg_rsp_t      cfg_o;
  hwpe_pkg::mem_req_t      mem_o;
  hwpe_pkg::mem_rsp_t      mem_i;
  logic                    evt_o;
  logic                    busy_o;
  logic [`HWPE_BEAT_W-1:0] mem     [MEM_BEATS];
  logic [`HWPE_BEAT_W-1:0] ref_mem [MEM_BEATS];
  job_row_t                job_tbl [N_JOBS];
  integer                  seed;

  hwpe_subsystem hwpe_subsystem_inst (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .cfg_i   ( cfg_i   ),
    .cfg_o   ( cfg_o   ),
    .mem_o   ( mem_o   ),
    .mem_i   ( mem_i   ),
    .evt_o   ( evt_o   ),
    .busy_o  ( busy_o  )
  );

  always #20 clk_i = ~clk_i;

  // shared memory, read data comes back one cycle after the strobe
  // a read and a write in the same cycle see the old contents on the read side
  initial begin
    seed = 32'h6699_0180;
    mem_i <= '0;
    for (int n = 0; n < MEM_BEATS; n++) begin
      mem[`HWPE_ADDR_W'(n)] <= {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    forever begin
      @(posedge clk_i);
      mem_i.rvalid <= mem_o.rd;
      if (mem_o.rd) begin
        mem_i.rdata <= mem[mem_o.rd_addr];
      end
      if (mem_o.wr) begin
        mem[mem_o.wr_addr] <= mem_o.wdata;
      end
    end
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic hwpe_pkg::cfg_req_t cfg_req(input logic we, input logic [2:0] addr,
                                                 input logic [`HWPE_WORD_W-1:0] wdata);
    hwpe_pkg::cfg_req_t r;
    r.valid = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // one-cycle strobe on the configuration port
  task automatic cfg_send(input logic we, input logic [2:0] addr,
                          input logic [`HWPE_WORD_W-1:0] wdata);
    @(posedge clk_i);
    cfg_i <= cfg_req(we, addr, wdata);
    @(posedge clk_i);
    cfg_i <= '0;
  endtask

  // the answer is due in the cycle right after the read strobe
  task automatic cfg_expect(input logic [2:0] addr, input logic [`HWPE_WORD_W-1:0] exp,
                            input string name);
    cfg_send(1'b0, addr, '0);
    @(negedge clk_i);
    assert (cfg_o.rvalid === 1'b1)
      else fail_run($sformatf("[ERROR] cfg_o.rvalid (%s) got %h expected 1", name, cfg_o.rvalid));
    assert (cfg_o.rdata === exp)
      else fail_run($sformatf("[ERROR] cfg_o.rdata (%s) got %h expected %h", name,
                              cfg_o.rdata, exp));
  endtask

  // expected beat, each 32-bit word handled on its own, lane 0 in the low bits
  function automatic logic [`HWPE_BEAT_W-1:0] transform(input logic [`HWPE_BEAT_W-1:0] beat,
                                                        input hwpe_pkg::hwpe_op_e op,
                                                        input logic [`HWPE_WORD_W-1:0] konst);
    logic [`HWPE_BEAT_W-1:0] res;
    logic [`HWPE_WORD_W-1:0] w;
    res = '0;
    for (int i = 0; i < `HWPE_N_LANES; i++) begin
      w = beat[`HWPE_WORD_W-1:0];
      case (op)
        hwpe_pkg::OP_ADD:  w = w + konst;
        hwpe_pkg::OP_XOR:  w = w ^ konst;
        hwpe_pkg::OP_FILL: w = konst;
        default:           w = w;
      endcase
      beat = beat >> `HWPE_WORD_W;
      res  = {w, res[`HWPE_BEAT_W-1:`HWPE_WORD_W]};
    end
    return res;
  endfunction

  // overlapping jobs stay under four beats apart, so reads always run ahead of writes
  // copy jobs carry a nonzero constant that the lanes must leave untouched
  task automatic load_jobs();
    job_tbl[0] = '{12'h010, 12'h200, 8'd1,  hwpe_pkg::OP_COPY, 32'h0F0F_3C3C, 1'b1};
    job_tbl[1] = '{12'h020, 12'h300, 8'd16, hwpe_pkg::OP_ADD,  32'hFFFF_FFF0, 1'b1};
    job_tbl[2] = '{12'h100, 12'h102, 8'd16, hwpe_pkg::OP_XOR,  32'hA5A5_5A5A, 1'b0};
    job_tbl[3] = '{12'h400, 12'h3FD, 8'd12, hwpe_pkg::OP_FILL, 32'h1234_5678, 1'b1};
    job_tbl[4] = '{12'h500, 12'h6F0, 8'd7,  hwpe_pkg::OP_ADD,  32'h0000_0001, 1'b0};
    job_tbl[5] = '{12'h104, 12'h800, 8'd16, hwpe_pkg::OP_COPY, 32'h8001_7FFE, 1'b1};
  endtask

  task automatic run_job(input job_row_t row);
    logic [`HWPE_BEAT_W-1:0] exp_q [$];
    logic [`HWPE_ADDR_W-1:0] a;
    int                      cyc;
    bit                      seen;
    cfg_send(1'b1, hwpe_pkg::REG_SRC,   32'(row.src));
    cfg_send(1'b1, hwpe_pkg::REG_DST,   32'(row.dst));
    cfg_send(1'b1, hwpe_pkg::REG_LEN,   32'(row.len));
    cfg_send(1'b1, hwpe_pkg::REG_OP,    32'(row.op));
    cfg_send(1'b1, hwpe_pkg::REG_CONST, row.konst);
    cfg_expect(hwpe_pkg::REG_SRC,   32'(row.src), "REG_SRC");
    cfg_expect(hwpe_pkg::REG_DST,   32'(row.dst), "REG_DST");
    cfg_expect(hwpe_pkg::REG_LEN,   32'(row.len), "REG_LEN");
    cfg_expect(hwpe_pkg::REG_OP,    32'(row.op),  "REG_OP");
    cfg_expect(hwpe_pkg::REG_CONST, row.konst,    "REG_CONST");
    for (int k = 0; k < int'(row.len); k++) begin
      exp_q.push_back(transform(ref_mem[row.src + `HWPE_ADDR_W'(k)], row.op, row.konst));
    end
    @(posedge clk_i);
    cfg_i <= cfg_req(1'b1, hwpe_pkg::REG_TRIGGER, 32'd1);
    @(negedge clk_i);
    assert (!busy_o) else fail_run("[ERROR] busy_o got 1 expected 0 in the trigger cycle");
    cyc  = 0;
    seen = 1'b0;
    // cycles are counted from the trigger, busy is due at 1 and the event at len+5
    while (!seen) begin
      @(posedge clk_i);
      cyc++;
      case (cyc)
        1: cfg_i <= row.poke ? cfg_req(1'b1, hwpe_pkg::REG_SRC, ~32'(row.src)) : '0;
        2: cfg_i <= row.poke ? cfg_req(1'b1, hwpe_pkg::REG_TRIGGER, 32'd1) : '0;
        3: cfg_i <= cfg_req(1'b0, hwpe_pkg::REG_STATUS, '0);
        4: cfg_i <= cfg_req(1'b0, hwpe_pkg::REG_SRC, '0);
        default: cfg_i <= '0;
      endcase
      @(negedge clk_i);
      if (cyc == 4) begin
        assert (cfg_o.rvalid && cfg_o.rdata == 32'd1)
          else fail_run($sformatf("[ERROR] REG_STATUS rvalid/rdata got %h/%h expected 1/1",
                                  cfg_o.rvalid, cfg_o.rdata));
      end
      if (cyc == 5) begin
        assert (cfg_o.rvalid && cfg_o.rdata == 32'(row.src))
          else fail_run($sformatf("[ERROR] REG_SRC in job got %h expected %h",
                                  cfg_o.rdata, 32'(row.src)));
      end
      if (evt_o) begin
        assert (cyc == int'(row.len) + 5)
          else fail_run($sformatf("[ERROR] evt_o cycle got %h expected %h",
                                  cyc, int'(row.len) + 5));
        assert (!busy_o) else fail_run("[ERROR] busy_o got 1 expected 0 with evt_o");
        seen = 1'b1;
      end else begin
        assert (busy_o) else fail_run("[ERROR] busy_o got 0 expected 1 before evt_o");
        if (cyc > int'(row.len) + 20) begin
          fail_run("timeout while waiting for evt_o");
        end
      end
    end
    // an ignored trigger would show up here as a second event
    repeat (8) begin
      @(negedge clk_i);
      assert (!evt_o && !busy_o)
        else fail_run($sformatf("[ERROR] {evt_o,busy_o} got %h expected 0 after the job",
                                {evt_o, busy_o}));
    end
    cfg_expect(hwpe_pkg::REG_SRC, 32'(row.src), "REG_SRC after job");
    // an idle engine reports a clear busy bit
    cfg_expect(hwpe_pkg::REG_STATUS, 32'd0, "REG_STATUS after job");
    for (int k = 0; k < int'(row.len); k++) begin
      ref_mem[row.dst + `HWPE_ADDR_W'(k)] = exp_q.pop_front();
    end
    // the whole memory is compared, so beats outside the target are covered too
    for (int n = 0; n < MEM_BEATS; n++) begin
      a = `HWPE_ADDR_W'(n);
      assert (mem[a] === ref_mem[a])
        else fail_run($sformatf("[ERROR] mem[%h] got %h expected %h", a, mem[a], ref_mem[a]));
    end
  endtask

  initial begin
    rst_n_i <= 1'b0;
    cfg_i   <= '0;
    load_jobs();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert ({busy_o, evt_o, mem_o.rd, mem_o.wr, cfg_o.rvalid} == 5'b0)
      else fail_run($sformatf("[ERROR] {busy_o,evt_o,rd,wr,rvalid} got %h expected 00",
                              {busy_o, evt_o, mem_o.rd, mem_o.wr, cfg_o.rvalid}));
    for (int n = 0; n < MEM_BEATS; n++) begin
      ref_mem[`HWPE_ADDR_W'(n)] = mem[`HWPE_ADDR_W'(n)];
    end
    for (int j = 0; j < N_JOBS; j++) begin
      run_job(job_tbl[j]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule
